/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP = memory_game_tb
FILELIST = sources.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_TEXT = Test completed successfully

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/memory_game.sv */
// Memory game score and timing core
`timescale 1ns/10ps

module memory_game
#(
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter memory_game_pkg::bcd_time_t START_SECONDS = 8'h60
)
(
	input logic clock,
	input logic reset_n,
	input memory_game_pkg::card_set_t cards,
	input logic flip,
	output memory_game_pkg::seg_t hex0,
	output memory_game_pkg::seg_t hex2,
	output memory_game_pkg::seg_t hex4,
	output memory_game_pkg::seg_t hex5,
	output memory_game_pkg::seg_t hex6,
	output memory_game_pkg::seg_t hex7,
	output memory_game_pkg::player_t turn
);

	memory_game_pkg::card_set_t card_a; // first pick
	memory_game_pkg::card_set_t card_b; // second pick
	logic check_valid;
	logic result_valid;
	logic is_match;
	logic time_up;
	logic game_over;
	logic blink;
	memory_game_pkg::score_t score_one;
	memory_game_pkg::score_t score_two;
	memory_game_pkg::score_t lead;
	memory_game_pkg::bcd_time_t seconds;

	pick_control u_pick_control (.clock, .reset_n, .cards, .flip, .card_a, .card_b,
		.check_valid);

	pair_checker u_pair_checker (.clock, .reset_n, .card_a, .card_b, .check_valid,
		.result_valid, .is_match);

	score_keeper u_score_keeper (.clock, .reset_n, .result_valid, .is_match, .time_up,
		.score_one, .score_two, .lead, .turn, .game_over);

	second_timer #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND),
		.START_SECONDS(START_SECONDS)
	) u_second_timer (
		.clock,
		.reset_n,
		.game_over, // freezes the countdown
		.seconds,
		.blink,
		.time_up
	);

	score_display u_score_display (.score_one, .score_two, .lead, .seconds, .blink,
		.game_over, .hex0, .hex2, .hex4, .hex5, .hex6, .hex7);

endmodule

/* design/memory_game_pkg.sv */
// Memory game shared definitions

package memory_game_pkg;

	localparam int NUM_CARDS = 18; // switches on the board
	localparam int NUM_PAIRS = 9; // also the count that ends a game

	typedef logic [NUM_CARDS-1:0] card_set_t; // one bit per card
	typedef logic [3:0] score_t; // score or lead digit
	typedef logic [7:0] bcd_time_t; // tens in [7:4], units in [3:0]
	typedef logic [6:0] seg_t; // active low, bit 0 is segment a

	typedef enum logic
	{
		PLAYER_ONE = 1'b0,
		PLAYER_TWO = 1'b1
	} player_t;

	// card indices of each pair, order within a pair does not matter
	localparam int PAIR_TABLE [NUM_PAIRS][2] = '{
		'{17, 10},
		'{16, 0},
		'{15, 4},
		'{14, 3},
		'{13, 2},
		'{12, 11},
		'{9, 7},
		'{8, 5},
		'{6, 1}
	};

	localparam seg_t SEG_BLANK = 7'b1111111; // all segments dark
	localparam seg_t SEG_P = 7'b0001100; // letter P

	// decimal digit to segment pattern
	function automatic seg_t seg_encode(input logic [3:0] digit);
		seg_t pattern;
		case (digit)
			4'd0: pattern = 7'b1000000;
			4'd1: pattern = 7'b1111001;
			4'd2: pattern = 7'b0100100;
			4'd3: pattern = 7'b0110000;
			4'd4: pattern = 7'b0011001;
			4'd5: pattern = 7'b0010010;
			4'd6: pattern = 7'b0000010;
			4'd7: pattern = 7'b1111000;
			4'd8: pattern = 7'b0000000;
			4'd9: pattern = 7'b0011000;
			default: pattern = SEG_BLANK; // not a decimal digit
		endcase
		return pattern;
	endfunction

endpackage

/* design/pair_checker.sv */
// Pair lookup and taken mask
`timescale 1ns/10ps

module pair_checker
(
	input logic clock,
	input logic reset_n,
	input memory_game_pkg::card_set_t card_a,
	input memory_game_pkg::card_set_t card_b,
	input logic check_valid,
	output logic result_valid,
	output logic is_match
);

	localparam int NUM_PAIRS = memory_game_pkg::NUM_PAIRS;

	logic [NUM_PAIRS-1:0] taken; // pairs already scored
	logic [NUM_PAIRS-1:0] take_mask; // pair claimed by this check
	logic found; // a free pair matches

	// first free table pair covered by the two picks
	always_comb
	begin
		int lo;
		int hi;
		logic hit;
		found = 1'b0;
		take_mask = '0;
		for (int p = 0; p < NUM_PAIRS; p++)
		begin
			lo = memory_game_pkg::PAIR_TABLE[p][1];
			hi = memory_game_pkg::PAIR_TABLE[p][0];
			hit = (card_a[hi] && card_b[lo]) || (card_a[lo] && card_b[hi]); // either order
			if (hit && !taken[p] && !found)
			begin
				found = 1'b1;
				take_mask[p] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			taken <= '0;
			result_valid <= 1'b0;
			is_match <= 1'b0;
		end
		else
		begin
			result_valid <= check_valid; // one cycle behind the strobe
			if (check_valid)
			begin
				is_match <= found; // empty, unrelated or taken is a miss
				taken <= taken | take_mask;
			end
		end
	end

	// taken pairs stay taken until the next reset
	taken_sticky: assert property (@(posedge clock) disable iff (!reset_n)
		$past(reset_n) |-> ((taken & $past(taken)) == $past(taken)));

endmodule

/* design/pick_control.sv */
// Flip button pick sequencer
`timescale 1ns/10ps

module pick_control
(
	input logic clock,
	input logic reset_n,
	input memory_game_pkg::card_set_t cards,
	input logic flip,
	output memory_game_pkg::card_set_t card_a,
	output memory_game_pkg::card_set_t card_b,
	output logic check_valid
);

	typedef enum logic [2:0]
	{
		PICK_FIRST,
		WAIT_FIRST,
		PICK_SECOND,
		WAIT_SECOND,
		CHECK,
		WAIT_CHECK
	} state_t;

	state_t state;
	logic flip_q; // flip level seen last cycle
	logic release_seen;

	assign release_seen = flip_q && !flip; // high then low

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			state <= PICK_FIRST;
			flip_q <= 1'b0;
			check_valid <= 1'b0;
		end
		else
		begin
			flip_q <= flip;
			check_valid <= 1'b0; // single cycle strobe
			case (state)
				PICK_FIRST: if (flip) state <= WAIT_FIRST;
				WAIT_FIRST: if (release_seen) state <= PICK_SECOND;
				PICK_SECOND: if (flip) state <= WAIT_SECOND;
				WAIT_SECOND: if (release_seen) state <= CHECK;
				CHECK: if (flip) state <= WAIT_CHECK;
				WAIT_CHECK:
				begin
					if (release_seen)
					begin
						check_valid <= 1'b1; // picks go to the checker
						state <= PICK_FIRST;
					end
				end
				default: state <= PICK_FIRST;
			endcase
		end
	end

	// picks are payload, held until the next pair of releases
	always_ff @(posedge clock)
	begin
		if (state == WAIT_FIRST && release_seen)
			card_a <= cards;
		if (state == WAIT_SECOND && release_seen)
			card_b <= cards;
	end

	// at least two release steps always separate two checks
	check_strobe_single: assert property (@(posedge clock) disable iff (!reset_n)
		check_valid |=> !check_valid);

endmodule

/* design/score_display.sv */
// Seven segment score and time display
`timescale 1ns/10ps

module score_display
(
	input memory_game_pkg::score_t score_one,
	input memory_game_pkg::score_t score_two,
	input memory_game_pkg::score_t lead,
	input memory_game_pkg::bcd_time_t seconds,
	input logic blink,
	input logic game_over,
	output memory_game_pkg::seg_t hex0,
	output memory_game_pkg::seg_t hex2,
	output memory_game_pkg::seg_t hex4,
	output memory_game_pkg::seg_t hex5,
	output memory_game_pkg::seg_t hex6,
	output memory_game_pkg::seg_t hex7
);

	logic dark; // blanking phase at game end

	assign dark = game_over && blink;

	assign hex0 = memory_game_pkg::seg_encode(score_two); // player two
	assign hex2 = memory_game_pkg::seg_encode(score_one); // player one
	assign hex4 = memory_game_pkg::seg_encode(seconds[3:0]); // units
	assign hex5 = memory_game_pkg::seg_encode(seconds[7:4]); // tens

	// marker and leader flash together once the game is over
	always_comb
	begin
		if (dark)
		begin
			hex7 = memory_game_pkg::SEG_BLANK;
			hex6 = memory_game_pkg::SEG_BLANK;
		end
		else
		begin
			hex7 = memory_game_pkg::SEG_P;
			hex6 = memory_game_pkg::seg_encode(lead); // 1, 2 or 0 for a tie
		end
	end

endmodule

/* design/score_keeper.sv */
// Scores, turn and end of game
`timescale 1ns/10ps

module score_keeper
(
	input logic clock,
	input logic reset_n,
	input logic result_valid,
	input logic is_match,
	input logic time_up,
	output memory_game_pkg::score_t score_one,
	output memory_game_pkg::score_t score_two,
	output memory_game_pkg::score_t lead,
	output memory_game_pkg::player_t turn,
	output logic game_over
);

	logic [3:0] pair_count; // pairs found by both players
	logic all_found;

	assign all_found = (pair_count == 4'(memory_game_pkg::NUM_PAIRS));

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			score_one <= '0;
			score_two <= '0;
			pair_count <= '0;
			turn <= memory_game_pkg::PLAYER_ONE;
			game_over <= 1'b0;
		end
		else
		begin
			game_over <= game_over || all_found || time_up; // held until reset
			if (result_valid && !game_over)
			begin
				if (is_match)
				begin
					pair_count <= pair_count + 4'd1;
					if (turn == memory_game_pkg::PLAYER_ONE)
						score_one <= score_one + 4'd1;
					else
						score_two <= score_two + 4'd1;
				end
				else if (turn == memory_game_pkg::PLAYER_ONE)
					turn <= memory_game_pkg::PLAYER_TWO; // miss passes the turn
				else
					turn <= memory_game_pkg::PLAYER_ONE;
			end
		end
	end

	// leader digit, 0 on a tie
	always_comb
	begin
		if (score_one > score_two)
			lead = 4'd1;
		else if (score_two > score_one)
			lead = 4'd2;
		else
			lead = 4'd0;
	end

	// results only ever add points
	scores_rise: assert property (@(posedge clock) disable iff (!reset_n)
		$past(reset_n) |-> (score_one >= $past(score_one) && score_two >= $past(score_two)));

endmodule

/* design/second_timer.sv */
// Seconds countdown and blink
`timescale 1ns/10ps

module second_timer
#(
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter memory_game_pkg::bcd_time_t START_SECONDS = 8'h60
)
(
	input logic clock,
	input logic reset_n,
	input logic game_over,
	output memory_game_pkg::bcd_time_t seconds,
	output logic blink,
	output logic time_up
);

	localparam int PRESCALE_W = $clog2(TICKS_PER_SECOND);

	logic [PRESCALE_W-1:0] prescale; // cycles within the current second
	logic tick;

	assign tick = (prescale == PRESCALE_W'(TICKS_PER_SECOND - 1));
	assign time_up = (seconds == 8'h00);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			prescale <= '0;
			seconds <= START_SECONDS;
			blink <= 1'b0;
		end
		else
		begin
			prescale <= tick ? '0 : prescale + 1'b1; // free running
			if (tick)
			begin
				blink <= !blink; // keeps going after the game ends
				if (!game_over && !time_up)
				begin
					if (seconds[3:0] == 4'd0)
					begin
						seconds[3:0] <= 4'd9; // borrow from tens
						seconds[7:4] <= seconds[7:4] - 4'd1;
					end
					else
						seconds[3:0] <= seconds[3:0] - 4'd1;
				end
			end
		end
	end

	bcd_digits_valid: assert property (@(posedge clock) disable iff (!reset_n)
		seconds[3:0] <= 4'd9 && seconds[7:4] <= 4'd9);

endmodule

/* sources.f */
design/memory_game_pkg.sv
design/pick_control.sv
design/pair_checker.sv
design/score_keeper.sv
design/second_timer.sv
design/score_display.sv
design/memory_game.sv
tb/memory_game_tb.sv

/* tb/memory_game_tb.sv */
// Memory game testbench
`timescale 1ns/10ps

module memory_game_tb;

	localparam int TICKS_PER_SECOND = 20; // short seconds for simulation
	localparam memory_game_pkg::bcd_time_t START_SECONDS = 8'h10; // ten seconds
	localparam int TURN_CYCLES = 10; // six flip cycles plus the settle wait
	localparam int TOTAL_TURNS = 16; // turns over all tests
	localparam int TIMER_CYCLES = 10 * TICKS_PER_SECOND;
	localparam int CYCLE_LIMIT = 2 * (TOTAL_TURNS * TURN_CYCLES + TIMER_CYCLES);
	localparam memory_game_pkg::seg_t SHOWN_P = ~7'h73; // segments a b e f g lit
	localparam memory_game_pkg::seg_t SHOWN_BLANK = 7'h7f; // all dark

	// the nine card pairs of the board
	localparam int PAIRS [9][2] = '{
		'{17, 10}, '{16, 0}, '{15, 4}, '{14, 3}, '{13, 2},
		'{12, 11}, '{9, 7}, '{8, 5}, '{6, 1}
	};

	logic clock = 1'b0;
	logic reset_n;
	memory_game_pkg::card_set_t cards;
	logic flip;
	memory_game_pkg::seg_t hex0;
	memory_game_pkg::seg_t hex2;
	memory_game_pkg::seg_t hex4;
	memory_game_pkg::seg_t hex5;
	memory_game_pkg::seg_t hex6;
	memory_game_pkg::seg_t hex7;
	memory_game_pkg::player_t turn;

	logic [8:0] exp_taken; // model of the taken mask
	logic [3:0] exp_score_one;
	logic [3:0] exp_score_two;
	logic exp_turn; // 0 is player one
	logic exp_game_over;
	int exp_pairs;
	logic check_en; // one cycle window for output checks
	logic time_check;
	logic freeze_watch;
	logic marker_watch;
	logic [7:0] shown_seconds; // seconds as read back from the digits
	int first_pair;
	int cycle_count = 0;
	int fail_count;
	int test_errors;
	int test_count;
	string test_name;

	always #50 clock = !clock;

	memory_game #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND),
		.START_SECONDS(START_SECONDS)
	) u_memory_game (.clock, .reset_n, .cards, .flip, .hex0, .hex2, .hex4, .hex5, .hex6,
		.hex7, .turn);

	// active low pattern of a decimal digit, bit 0 is segment a
	function automatic memory_game_pkg::seg_t digit_pattern(input logic [3:0] digit);
		logic [6:0] lit;
		case (digit)
			4'd0: lit = 7'h3f;
			4'd1: lit = 7'h06;
			4'd2: lit = 7'h5b;
			4'd3: lit = 7'h4f;
			4'd4: lit = 7'h66;
			4'd5: lit = 7'h6d;
			4'd6: lit = 7'h7d;
			4'd7: lit = 7'h07;
			4'd8: lit = 7'h7f;
			4'd9: lit = 7'h67; // nine without the bottom bar
			default: lit = 7'h00;
		endcase
		return ~lit;
	endfunction

	// digit behind a pattern, 15 when none
	function automatic logic [3:0] shown_digit(input memory_game_pkg::seg_t pattern);
		logic [3:0] digit;
		digit = 4'd15;
		for (int d = 0; d < 10; d++)
			if (digit_pattern(4'(d)) == pattern)
				digit = 4'(d);
		return digit;
	endfunction

	function automatic logic [3:0] lead_of(input logic [3:0] one, input logic [3:0] two);
		if (one > two)
			return 4'd1;
		if (two > one)
			return 4'd2;
		return 4'd0; // tie
	endfunction

	function automatic int pair_index(input int first, input int second);
		for (int p = 0; p < 9; p++)
			if ((PAIRS[p][0] == first && PAIRS[p][1] == second) ||
				(PAIRS[p][1] == first && PAIRS[p][0] == second))
				return p;
		return -1; // not a pair
	endfunction

	function automatic memory_game_pkg::card_set_t card_bit(input int index);
		return memory_game_pkg::card_set_t'(1) << index;
	endfunction

	assign shown_seconds = {shown_digit(hex5), shown_digit(hex4)};

	task automatic report_value(input string what, input memory_game_pkg::seg_t expected,
		input memory_game_pkg::seg_t actual);
		$display("Fail %s: %s expected %b actual %b", test_name, what, expected, actual);
		fail_count++;
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("Error in %s: %s", test_name, what);
		fail_count++;
		test_errors++;
	endtask

	score_two_shown: assert property (@(posedge clock) disable iff (!reset_n)
		check_en |-> hex0 == digit_pattern(exp_score_two))
		else report_value("hex0", digit_pattern(exp_score_two), $sampled(hex0));

	score_one_shown: assert property (@(posedge clock) disable iff (!reset_n)
		check_en |-> hex2 == digit_pattern(exp_score_one))
		else report_value("hex2", digit_pattern(exp_score_one), $sampled(hex2));

	lead_shown: assert property (@(posedge clock) disable iff (!reset_n)
		check_en |-> hex6 == digit_pattern(lead_of(exp_score_one, exp_score_two)) ||
			(exp_game_over && hex6 == SHOWN_BLANK)) // blinks after the end
		else report_value("hex6", digit_pattern(lead_of(exp_score_one, exp_score_two)),
			$sampled(hex6));

	marker_shown: assert property (@(posedge clock) disable iff (!reset_n)
		check_en |-> hex7 == SHOWN_P || (exp_game_over && hex7 == SHOWN_BLANK))
		else report_value("hex7", SHOWN_P, $sampled(hex7));

	turn_shown: assert property (@(posedge clock) disable iff (!reset_n)
		check_en |-> turn == exp_turn)
		else report_value("turn", 7'(exp_turn), 7'($sampled(turn)));

	tens_at_start: assert property (@(posedge clock) disable iff (!reset_n)
		time_check |-> hex5 == digit_pattern(START_SECONDS[7:4]))
		else report_value("hex5", digit_pattern(START_SECONDS[7:4]), $sampled(hex5));

	units_at_start: assert property (@(posedge clock) disable iff (!reset_n)
		time_check |-> hex4 == digit_pattern(START_SECONDS[3:0]))
		else report_value("hex4", digit_pattern(START_SECONDS[3:0]), $sampled(hex4));

	time_frozen: assert property (@(posedge clock) disable iff (!reset_n)
		freeze_watch |-> $stable(shown_seconds))
		else report_problem("the seconds kept changing after the game ended");

	never_counts_up: assert property (@(posedge clock) disable iff (!reset_n)
		shown_seconds <= $past(shown_seconds))
		else report_problem("the seconds display counted up");

	marker_only_p: assert property (@(posedge clock) disable iff (!reset_n)
		marker_watch |-> hex7 == SHOWN_P || hex7 == SHOWN_BLANK)
		else report_problem("the marker showed something other than P or blank");

	always @(posedge clock)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	task automatic apply_reset();
		@(negedge clock);
		reset_n = 1'b0;
		flip = 1'b0;
		cards = '0;
		repeat (8) @(negedge clock);
		reset_n = 1'b1;
		exp_taken = '0; // model back to its start
		exp_score_one = 4'd0;
		exp_score_two = 4'd0;
		exp_turn = 1'b0;
		exp_game_over = 1'b0;
		exp_pairs = 0;
	endtask

	// press on one falling edge, release on the next
	task automatic press_flip(input memory_game_pkg::card_set_t value);
		@(negedge clock);
		cards = value; // held through the release edge
		flip = 1'b1;
		@(negedge clock);
		flip = 1'b0;
	endtask

	task automatic update_model(input int first, input int second);
		int p;
		logic [8:0] mask;
		p = pair_index(first, second);
		mask = (p >= 0) ? 9'(1) << p : '0;
		if (exp_game_over)
			return; // nothing scores after the end
		if (p >= 0 && (exp_taken & mask) == '0)
		begin
			exp_taken = exp_taken | mask;
			if (exp_turn)
				exp_score_two = exp_score_two + 4'd1;
			else
				exp_score_one = exp_score_one + 4'd1;
			exp_pairs++;
			exp_game_over = (exp_pairs == 9);
		end
		else
			exp_turn = !exp_turn; // miss
	endtask

	task automatic check_outputs(input logic with_time);
		@(negedge clock);
		check_en = 1'b1;
		time_check = with_time;
		@(negedge clock);
		check_en = 1'b0;
		time_check = 1'b0;
	endtask

	task automatic play_turn(input int first, input int second);
		press_flip(card_bit(first));
		press_flip(card_bit(second));
		press_flip(card_bit(second)); // check the pair
		repeat (4) @(negedge clock);
		update_model(first, second);
		check_outputs(1'b0);
	endtask

	task automatic play_pair(input int p);
		if ($urandom % 2 == 0)
			play_turn(PAIRS[p][0], PAIRS[p][1]);
		else
			play_turn(PAIRS[p][1], PAIRS[p][0]); // reversed order
	endtask

	task automatic play_miss();
		int first;
		int second;
		first = $urandom % 18;
		second = $urandom % 18;
		while (second == first || pair_index(first, second) >= 0)
			second = $urandom % 18;
		play_turn(first, second);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		test_count++;
		$display("%s finished with %0d errors", test_name, test_errors);
	endtask

	task automatic timer_test();
		logic saw_p;
		logic saw_blank;
		saw_p = 1'b0;
		saw_blank = 1'b0;
		start_test("timer_runs_out");
		apply_reset();
		while (hex5 != digit_pattern(4'd0) || hex4 != digit_pattern(4'd0))
			@(negedge clock);
		exp_game_over = 1'b1; // time up ends the game
		repeat (2) @(negedge clock);
		play_pair($urandom % 9);
		marker_watch = 1'b1;
		repeat (4 * TICKS_PER_SECOND)
		begin
			@(negedge clock);
			saw_p = saw_p || (hex7 == SHOWN_P);
			saw_blank = saw_blank || (hex7 == SHOWN_BLANK);
		end
		marker_watch = 1'b0;
		marker_blinked: assert (saw_p && saw_blank)
			else report_problem("the marker did not blink after the timer ran out");
		finish_test();
	endtask

	initial
	begin
		int p;
		void'($urandom(87195));
		reset_n = 1'b0;
		flip = 1'b0;
		cards = '0;
		check_en = 1'b0;
		time_check = 1'b0;
		freeze_watch = 1'b0;
		marker_watch = 1'b0;
		fail_count = 0;
		test_count = 0;

		start_test("after_reset");
		apply_reset();
		check_outputs(1'b1); // also the start time
		finish_test();

		start_test("first_pair");
		first_pair = $urandom % 9;
		play_pair(first_pair);
		finish_test();

		start_test("misses");
		play_miss(); // unrelated cards
		play_pair(first_pair); // already taken
		finish_test();

		start_test("second_player");
		play_miss();
		p = $urandom % 9;
		while (exp_taken[p])
			p = $urandom % 9;
		play_pair(p); // tie afterwards
		finish_test();

		start_test("all_pairs");
		apply_reset();
		for (int q = 0; q < 9; q++)
			play_pair(q);
		play_pair(0); // after the end, no score
		@(negedge clock);
		freeze_watch = 1'b1;
		repeat (3 * TICKS_PER_SECOND) @(negedge clock);
		freeze_watch = 1'b0;
		finish_test();

		timer_test();

		$display("%0d tests run, %0d checks failed", test_count, fail_count);
		if (fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
